//--- Bender.yml
package:
  name: axi_dma_wr

sources:
  - logic/dma_wr_pkg.sv
  - logic/sync_fifo.sv
  - logic/burst_planner.sv
  - logic/dma_wr_ctrl.sv
  - logic/wr_completion.sv
  - logic/axi_dma_wr.sv
  - target: test
    files:
      - testbench/axi_dma_wr_checker.sv
      - testbench/axi_dma_wr_tb.sv

//--- compile.f
logic/dma_wr_pkg.sv
logic/sync_fifo.sv
logic/burst_planner.sv
logic/dma_wr_ctrl.sv
logic/wr_completion.sv
logic/axi_dma_wr.sv
testbench/axi_dma_wr_checker.sv
testbench/axi_dma_wr_tb.sv

//--- logic/axi_dma_wr.sv
// stream to AXI4 write DMA top; AXI id is fixed at zero and bursts are full width INCR
`default_nettype none

module axi_dma_wr (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire dma_wr_pkg::wr_desc_t          req,
    input  wire logic                          req_valid,
    output logic                               req_ready,
    output dma_wr_pkg::wr_sts_t                sts,
    output logic                               sts_valid,
    input  wire logic [dma_wr_pkg::data_w-1:0] s_data,
    input  wire logic                          s_valid,
    input  wire logic                          s_last,
    output logic                               s_ready,
    output dma_wr_pkg::aw_beat_t               aw,
    output logic                               awvalid,
    input  wire logic                          awready,
    output logic [2:0]                         awsize,
    output logic [1:0]                         awburst,
    output logic [3:0]                         awcache,
    output logic [2:0]                         awprot,
    output dma_wr_pkg::w_beat_t                w,
    output logic                               wvalid,
    input  wire logic                          wready,
    input  wire logic [1:0]                    bresp,
    input  wire logic                          bvalid,
    output logic                               bready,
    input  wire logic                          enable
);

    import dma_wr_pkg::*;

    logic               plan_load;
    logic               plan_advance;
    logic [addr_w-1:0]  burst_addr;
    logic [bytes_w-1:0] burst_bytes;
    logic [beats_w-1:0] burst_beats;
    logic [len_w-1:0]   remaining;
    logic               w_push;
    w_beat_t            w_beat;
    logic               w_half_full;
    logic               w_empty;
    logic               sts_push;
    sts_entry_t         sts_entry_in;
    sts_entry_t         sts_entry_out;
    logic               sts_empty;
    logic               sts_pop;
    logic               slot_free;
    logic               burst_issued;

    assign awsize = 3'(addr_lsb);
    assign awburst = 2'b01;
    assign awcache = 4'b0011;
    assign awprot = 3'b010;
    assign wvalid = !w_empty;

    dma_wr_ctrl ctrl_i (
        .clk, .rst, .enable, .req, .req_valid, .req_ready,
        .s_data, .s_valid, .s_last, .s_ready, .aw, .awvalid, .awready,
        .plan_load, .plan_advance, .burst_addr, .burst_bytes, .burst_beats, .remaining,
        .w_push, .w_beat, .w_half_full, .sts_push, .sts_entry(sts_entry_in),
        .slot_free, .burst_issued
    );

    burst_planner planner_i (
        .clk, .rst, .load(plan_load), .desc(req), .advance(plan_advance),
        .burst_addr, .burst_bytes, .burst_beats, .remaining
    );

    sync_fifo #(.payload_t(w_beat_t), .aw(fifo_aw)) w_fifo_i (
        .clk, .rst, .push(w_push), .push_data(w_beat), .pop(wvalid && wready),
        .pop_data(w), .empty(w_empty), .half_full(w_half_full)
    );

    sync_fifo #(.payload_t(sts_entry_t), .aw(fifo_aw)) sts_fifo_i (
        .clk, .rst, .push(sts_push), .push_data(sts_entry_in), .pop(sts_pop),
        .pop_data(sts_entry_out), .empty(sts_empty), .half_full()
    );

    wr_completion completion_i (
        .clk, .rst, .sts_entry(sts_entry_out), .sts_empty, .sts_pop,
        .bresp, .bvalid, .bready, .burst_issued, .slot_free, .sts, .sts_valid
    );

endmodule

`default_nettype wire

//--- logic/burst_planner.sv
// burst planner for word-aligned INCR bursts; low address bits of a descriptor are dropped
`default_nettype none

module burst_planner (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           load,
    input  wire dma_wr_pkg::wr_desc_t           desc,
    input  wire logic                           advance,
    output logic [dma_wr_pkg::addr_w-1:0]       burst_addr,
    output logic [dma_wr_pkg::bytes_w-1:0]      burst_bytes,
    output logic [dma_wr_pkg::beats_w-1:0]      burst_beats,
    output logic [dma_wr_pkg::len_w-1:0]        remaining
);

    import dma_wr_pkg::*;

    logic [addr_w-1:0] addr_q;
    logic [len_w-1:0]  rem_q;
    logic [12:0]       room;
    logic [12:0]       cap;
    logic [12:0]       bytes_next;

    // bytes left before the next 4 KiB line
    assign room = 13'h1000 - {1'b0, addr_q[11:0]};
    assign cap = (room < 13'(max_burst_bytes)) ? room : 13'(max_burst_bytes);

    assign bytes_next = (rem_q < len_w'(cap)) ? 13'(rem_q) : cap;

    assign burst_addr = addr_q;
    assign burst_bytes = bytes_w'(bytes_next);
    // partial tail word still needs a full beat
    assign burst_beats = beats_w'((bytes_next + 13'(strb_w - 1)) >> addr_lsb);
    assign remaining = rem_q;

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q <= desc.addr & ~addr_w'(strb_w - 1);
            rem_q <= desc.len;
        end else if (advance) begin
            addr_q <= addr_q + addr_w'(burst_bytes);
            rem_q <= rem_q - len_w'(burst_bytes);
        end

        if (rst) begin
            rem_q <= '0;
        end
    end

    // an issued burst never runs past a 4 KiB line
    assert property (@(posedge clk) disable iff (rst)
        advance |-> ({1'b0, burst_addr[11:0]} + 13'(burst_bytes)) <= 13'h1000);

endmodule

`default_nettype wire

//--- logic/dma_wr_ctrl.sv
// write DMA control FSM; descriptor length must be nonzero and every stream word is taken as full
`default_nettype none

module dma_wr_ctrl (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           enable,
    input  wire dma_wr_pkg::wr_desc_t           req,
    input  wire logic                           req_valid,
    output logic                                req_ready,
    input  wire logic [dma_wr_pkg::data_w-1:0]  s_data,
    input  wire logic                           s_valid,
    input  wire logic                           s_last,
    output logic                                s_ready,
    output dma_wr_pkg::aw_beat_t                aw,
    output logic                                awvalid,
    input  wire logic                           awready,
    output logic                                plan_load,
    output logic                                plan_advance,
    input  wire logic [dma_wr_pkg::addr_w-1:0]  burst_addr,
    input  wire logic [dma_wr_pkg::bytes_w-1:0] burst_bytes,
    input  wire logic [dma_wr_pkg::beats_w-1:0] burst_beats,
    input  wire logic [dma_wr_pkg::len_w-1:0]   remaining,
    output logic                                w_push,
    output dma_wr_pkg::w_beat_t                 w_beat,
    input  wire logic                           w_half_full,
    output logic                                sts_push,
    output dma_wr_pkg::sts_entry_t              sts_entry,
    input  wire logic                           slot_free,
    output logic                                burst_issued
);

    import dma_wr_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_write,
        st_finish,
        st_drop
    } state_t;

    state_t state;
    state_t state_next;

    logic               idle_q;
    logic               first_q;
    logic               last_burst_q;
    logic [tag_w-1:0]   tag_q;
    logic [len_w-1:0]   total_q;
    logic [beats_w-1:0] beats_left;
    logic [bytes_w-1:0] bytes_left;
    logic [bytes_w-1:0] step;
    logic [strb_w-1:0]  strb_trim;
    logic               aw_go;
    logic               beat_go;
    logic               pad_go;
    logic               burst_end;

    assign req_ready = idle_q && enable && slot_free;
    assign s_ready = (state == st_write && !w_half_full) || state == st_drop;
    assign burst_issued = awvalid && awready;
    assign plan_load = req_valid && req_ready;

    // first burst holds AW back until stream data shows up
    assign aw_go = state == st_start && !awvalid && slot_free && (s_valid || !first_q);
    assign plan_advance = aw_go;

    assign beat_go = state == st_write && s_valid && s_ready;
    assign pad_go = state == st_finish && !w_half_full;
    assign burst_end = beats_left == beats_w'(1);

    assign step = (bytes_left >= bytes_w'(strb_w)) ? bytes_w'(strb_w) : bytes_left;
    assign strb_trim = (bytes_left >= bytes_w'(strb_w)) ? '1 : strb_w'((1 << bytes_left) - 1);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (plan_load) begin
                    state_next = st_start;
                end
            end
            st_start: begin
                if (aw_go) begin
                    state_next = st_write;
                end
            end
            st_write: begin
                if (beat_go) begin
                    if (burst_end && s_last) begin
                        state_next = st_idle;
                    end else if (burst_end && last_burst_q) begin
                        // descriptor used up, rest of the frame goes
                        state_next = st_drop;
                    end else if (burst_end) begin
                        state_next = st_start;
                    end else if (s_last) begin
                        state_next = st_finish;
                    end
                end
            end
            st_finish: begin
                if (pad_go && burst_end) begin
                    state_next = st_idle;
                end
            end
            st_drop: begin
                if (s_valid && s_last) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        state <= state_next;
        idle_q <= state_next == st_idle;
        awvalid <= awvalid && !awready;
        w_push <= beat_go || pad_go;
        sts_push <= beat_go && (burst_end || s_last);

        if (plan_load) begin
            tag_q <= req.tag;
            total_q <= '0;
            first_q <= 1'b1;
        end

        if (aw_go) begin
            awvalid <= 1'b1;
            aw.addr <= burst_addr;
            aw.len <= 8'(burst_beats - 1'b1);
            beats_left <= burst_beats;
            bytes_left <= burst_bytes;
            last_burst_q <= remaining == len_w'(burst_bytes);
            first_q <= 1'b0;
        end

        if (beat_go) begin
            w_beat.data <= s_data;
            w_beat.strb <= strb_trim;
            w_beat.last <= burst_end;
            total_q <= total_q + len_w'(step);
            sts_entry.len <= total_q + len_w'(step);
            sts_entry.tag <= tag_q;
            sts_entry.last <= last_burst_q || s_last;
        end

        // zero strobe filler after an early end of frame
        if (pad_go) begin
            w_beat.data <= '0;
            w_beat.strb <= '0;
            w_beat.last <= burst_end;
        end

        if (beat_go || pad_go) begin
            beats_left <= beats_left - 1'b1;
            bytes_left <= bytes_left - step;
        end

        if (rst) begin
            state <= st_idle;
            idle_q <= 1'b0;
            awvalid <= 1'b0;
            w_push <= 1'b0;
            sts_push <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw));

endmodule

`default_nettype wire

//--- logic/dma_wr_pkg.sv
// write DMA shared definitions; addresses are word aligned and the stream width equals the AXI data width
`default_nettype none

package dma_wr_pkg;

    // bus and descriptor widths
    localparam int data_w = 32;
    localparam int strb_w = 4;
    localparam int addr_w = 32;
    localparam int len_w = 16;
    localparam int tag_w = 8;

    localparam int max_burst_len = 16;
    localparam int fifo_aw = 5;

    // derived burst limits
    localparam int addr_lsb = $clog2(strb_w);
    localparam int max_burst_bytes = max_burst_len * strb_w;
    localparam int bytes_w = $clog2(max_burst_bytes + 1);
    localparam int beats_w = $clog2(max_burst_len + 1);

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;
    localparam logic [1:0] resp_decerr = 2'b11;

    localparam logic [3:0] err_none = 4'd0;
    localparam logic [3:0] err_wr_slverr = 4'd6;
    localparam logic [3:0] err_wr_decerr = 4'd7;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
        logic [tag_w-1:0]  tag;
    } wr_desc_t;

    typedef struct packed {
        logic [len_w-1:0] len;
        logic [tag_w-1:0] tag;
        logic [3:0]       error;
    } wr_sts_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
    } aw_beat_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } w_beat_t;

    // one entry per burst, last marks the final burst of a descriptor
    typedef struct packed {
        logic [len_w-1:0] len;
        logic [tag_w-1:0] tag;
        logic             last;
    } sts_entry_t;

endpackage

`default_nettype wire

//--- logic/sync_fifo.sv
// synchronous FIFO with registered half-full flag; the producer must not push while full
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  aw        = 5
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      pop_data,
    output logic          empty,
    output logic          half_full
);

    payload_t mem [2**aw];

    // pointers carry one extra wrap bit
    logic [aw:0] wr_ptr;
    logic [aw:0] rd_ptr;
    logic [aw:0] fill;
    logic        full;

    assign empty = wr_ptr == rd_ptr;
    assign full = wr_ptr == (rd_ptr ^ {1'b1, {aw{1'b0}}});
    assign fill = wr_ptr - rd_ptr;
    assign pop_data = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[aw-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            half_full <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            half_full <= fill >= (aw+1)'(2**(aw-1));
        end
    end

    // producers and consumers in other modules must respect the flags
    assert property (@(posedge clk) disable iff (rst) !(push && full) && !(pop && empty));

endmodule

`default_nettype wire

//--- logic/wr_completion.sv
// write response tracking; B responses must arrive in AW order as AXI requires with a single id
`default_nettype none

module wr_completion (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire dma_wr_pkg::sts_entry_t  sts_entry,
    input  wire logic                    sts_empty,
    output logic                         sts_pop,
    input  wire logic [1:0]              bresp,
    input  wire logic                    bvalid,
    output logic                         bready,
    input  wire logic                    burst_issued,
    output logic                         slot_free,
    output dma_wr_pkg::wr_sts_t          sts,
    output logic                         sts_valid
);

    import dma_wr_pkg::*;

    logic [1:0]       worst_q;
    logic [1:0]       worst_next;
    logic [3:0]       err_code;
    logic [fifo_aw:0] outstanding;

    // a queued entry means a burst is waiting for its response
    assign bready = !sts_empty;
    assign sts_pop = bvalid && bready;
    assign slot_free = outstanding < (fifo_aw+1)'(2**fifo_aw);

    always_comb begin
        worst_next = worst_q;
        if (sts_pop && (bresp == resp_slverr || bresp == resp_decerr) && bresp > worst_q) begin
            worst_next = bresp;
        end

        case (worst_next)
            resp_slverr: err_code = err_wr_slverr;
            resp_decerr: err_code = err_wr_decerr;
            default:     err_code = err_none;
        endcase
    end

    always_ff @(posedge clk) begin
        sts_valid <= 1'b0;
        worst_q <= worst_next;

        if (sts_pop && sts_entry.last) begin
            sts.len <= sts_entry.len;
            sts.tag <= sts_entry.tag;
            sts.error <= err_code;
            sts_valid <= 1'b1;
            worst_q <= resp_okay;
        end

        case ({burst_issued, sts_pop})
            2'b10:   outstanding <= outstanding + 1'b1;
            2'b01:   outstanding <= outstanding - 1'b1;
            default: outstanding <= outstanding;
        endcase

        if (rst) begin
            sts_valid <= 1'b0;
            worst_q <= resp_okay;
            outstanding <= '0;
        end
    end

    // controller only raises AW with a slot in hand
    assert property (@(posedge clk) disable iff (rst) burst_issued |-> slot_free);

endmodule

`default_nettype wire

//--- testbench/axi_dma_wr_checker.sv
// write DMA checker; rows must be queued before their descriptor is sent and memory stays below 16 KiB
`default_nettype none

module axi_dma_wr_checker (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 enable,
    input wire logic                 req_ready,
    input wire dma_wr_pkg::aw_beat_t aw,
    input wire logic                 awvalid,
    input wire logic                 awready,
    input wire logic [2:0]           awsize,
    input wire logic [1:0]           awburst,
    input wire logic [3:0]           awcache,
    input wire logic [2:0]           awprot,
    input wire dma_wr_pkg::w_beat_t  w,
    input wire logic                 wvalid,
    input wire logic                 wready,
    input wire logic                 bvalid,
    input wire logic                 bready,
    input wire dma_wr_pkg::wr_sts_t  sts,
    input wire logic                 sts_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    import dma_wr_pkg::*;

    aw_beat_t   aw_exp [$];
    w_beat_t    w_exp [$];
    bit         fin_q [$];
    wr_sts_t    sts_exp [$];
    logic [7:0] exp_mem [16384];
    bit         written [16384];
    int         errors = 0;
    int         checks = 0;
    bit         sts_due = 0;

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a ^ (a >> 8) ^ (a >> 13) ^ 8'h5a);
    endfunction

    function automatic logic [31:0] stream_word(input int tag, input int k);
        return {8'(tag), 8'hc3, 16'(k)};
    endfunction

    function automatic int pending();
        return aw_exp.size() + w_exp.size() + fin_q.size() + sts_exp.size();
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic note(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // splits a row into bursts under the 16 beat and 4 KiB rules
    task automatic expect_row(input logic [31:0] addr, input int len, input int tag,
                              input int words, input int err_burst, input logic [1:0] err_resp,
                              output int nb);
        logic [31:0] a;
        logic [31:0] wd;
        logic [1:0]  worst;
        int          rem;
        int          off;
        int          sent;
        int          bb;
        int          beats;
        int          g;
        int          r;
        int          total;
        w_beat_t     wb;
        wr_sts_t     st;
        a = addr & ~32'd3;
        rem = len;
        off = 0;
        nb = 0;
        sent = 4 * words;
        worst = resp_okay;
        while (rem > 0 && off < sent) begin
            bb = 4096 - int'(a % 4096);
            if (bb > 64) bb = 64;
            if (bb > rem) bb = rem;
            beats = (bb + 3) / 4;
            aw_exp.push_back({a, 8'(beats - 1)});
            for (int j = 0; j < beats; j++) begin
                g = off / 4 + j;
                r = len - 4 * g;
                wb.data = (g < words) ? stream_word(tag, g) : '0;
                wb.strb = (g >= words) ? 4'h0 : (r >= 4) ? 4'hf : 4'((1 << r) - 1);
                wb.last = j == beats - 1;
                w_exp.push_back(wb);
            end
            fin_q.push_back(rem == bb || off + bb >= sent);
            if (nb == err_burst) worst = err_resp;
            a += bb;
            off += bb;
            rem -= bb;
            nb++;
        end
        total = (sent < len) ? sent : len;
        for (int i = 0; i < total; i++) begin
            wd = stream_word(tag, i / 4);
            exp_mem[((addr & ~32'd3) + i) % 16384] = wd[8 * (i % 4) +: 8];
            written[((addr & ~32'd3) + i) % 16384] = 1'b1;
        end
        st.len = 16'(total);
        st.tag = 8'(tag);
        st.error = (worst == resp_decerr) ? err_wr_decerr :
                   (worst == resp_slverr) ? err_wr_slverr : err_none;
        sts_exp.push_back(st);
    endtask

    task automatic close_out();
        logic [7:0] e;
        if (pending() != 0) note("expected bursts, beats or status were never seen");
        for (int a = 0; a < 16384; a++) begin
            e = written[a] ? exp_mem[a] : fill_byte(a);
            if (axi_dma_wr_tb.mem[a] !== e) begin
                check_val($sformatf("mem[%h]", a), axi_dma_wr_tb.mem[a], e);
            end
        end
    endtask

    always @(posedge clk) begin : watch
        aw_beat_t ea;
        w_beat_t  ew;
        wr_sts_t  es;
        if (!rst) begin
            if (!enable && req_ready) note("req_ready high while enable is low");
            if (sts_valid !== sts_due) note("sts_valid not one cycle after the final B response");
            sts_due = 0;
            if (awvalid && awready) begin
                if (aw.len > 8'd15) note("AW burst longer than 16 beats");
                if (int'(aw.addr % 4096) + 4 * (int'(aw.len) + 1) > 4096) begin
                    note("AW burst crosses a 4 KiB line");
                end
                // full width INCR bursts, normal non-secure data access
                check_val("awsize", awsize, 3'($clog2(strb_w)));
                check_val("awburst", awburst, 2'b01);
                check_val("awcache", awcache, 4'b0011);
                check_val("awprot", awprot, 3'b010);
                if (aw_exp.size() == 0) begin
                    note("unexpected AW burst");
                end else begin
                    ea = aw_exp.pop_front();
                    check_val("aw.addr", aw.addr, ea.addr);
                    check_val("aw.len", aw.len, ea.len);
                end
            end
            if (wvalid && wready) begin
                if (w_exp.size() == 0) begin
                    note("unexpected W beat");
                end else begin
                    ew = w_exp.pop_front();
                    check_val("w.data", w.data, ew.data);
                    check_val("w.strb", w.strb, ew.strb);
                    check_val("w.last", w.last, ew.last);
                end
            end
            if (bvalid && bready) begin
                if (fin_q.size() == 0) note("unexpected B response");
                else sts_due = fin_q.pop_front();
            end
            if (sts_valid) begin
                if (sts_exp.size() == 0) begin
                    note("unexpected status");
                end else begin
                    es = sts_exp.pop_front();
                    check_val("sts.len", sts.len, es.len);
                    check_val("sts.tag", sts.tag, es.tag);
                    check_val("sts.error", sts.error, es.error);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/axi_dma_wr_tb.sv
// write DMA testbench; slave memory covers 16 KiB and accepts W beats only after their AW
`default_nettype none

module axi_dma_wr_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import dma_wr_pkg::*;

    typedef struct packed {
        logic [31:0] addr;
        logic [15:0] len;
        logic [7:0]  tag;
        logic [15:0] words;
        logic [7:0]  err_burst;
        logic [1:0]  err_resp;
        logic        enable;
    } row_t;

    logic        clk;
    logic        rst;
    wr_desc_t    req;
    logic        req_valid;
    logic        req_ready;
    wr_sts_t     sts;
    logic        sts_valid;
    logic [31:0] s_data;
    logic        s_valid;
    logic        s_last;
    logic        s_ready;
    aw_beat_t    aw;
    logic        awvalid;
    logic        awready;
    logic [2:0]  awsize;
    logic [1:0]  awburst;
    logic [3:0]  awcache;
    logic [2:0]  awprot;
    w_beat_t     w;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic        enable;

    row_t        rows [11];
    aw_beat_t    aw_q [$];
    logic [1:0]  b_q [$];
    logic [1:0]  resp_q [$];
    logic [7:0]  mem [16384];
    logic [31:0] rng = 32'd34;
    int          wcnt = 0;
    bit          b_hs = 0;
    bit          timed_out = 0;

    axi_dma_wr axi_dma_wr_i (.*);

    axi_dma_wr_checker chk_i (
        .clk, .rst, .enable, .req_ready, .aw, .awvalid, .awready,
        .awsize, .awburst, .awcache, .awprot, .w, .wvalid, .wready,
        .bvalid, .bready, .sts, .sts_valid
    );

    function logic [31:0] xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // slave memory model samples handshakes on the edge
    always @(posedge clk) begin : sample
        logic [31:0] wa;
        b_hs = bvalid && bready && !rst;
        if (!rst && awvalid && awready) aw_q.push_back(aw);
        if (!rst && wvalid && wready) begin
            wa = aw_q[0].addr + 32'(4 * wcnt);
            for (int j = 0; j < 4; j++) begin
                if (w.strb[j]) mem[(wa + j) % 16384] = w.data[8 * j +: 8];
            end
            wcnt++;
            if (w.last) begin
                void'(aw_q.pop_front());
                b_q.push_back(resp_q.pop_front());
                wcnt = 0;
            end
        end
        if (b_hs) void'(b_q.pop_front());
    end

    // random back-pressure with bvalid held until taken
    always @(posedge clk) begin
        #1;
        awready = xorshift() % 4 != 0;
        wready = aw_q.size() != 0 && xorshift() % 3 != 0;
        if (!bvalid || b_hs) bvalid = b_q.size() != 0 && xorshift() % 4 == 0;
        bresp = (b_q.size() != 0) ? b_q[0] : resp_okay;
    end

    task automatic await_ready(input bit stream);
        int n;
        n = 0;
        @(posedge clk);
        while (!(stream ? s_ready : req_ready) && n < 2000) begin
            n++;
            @(posedge clk);
        end
        if (!(stream ? s_ready : req_ready)) begin
            chk_i.note($sformatf("timeout waiting for %s ready",
                                 stream ? "stream" : "descriptor"));
            timed_out = 1'b1;
        end
        #1;
    endtask

    task automatic run_row(input row_t r);
        int nb;
        chk_i.expect_row(r.addr, r.len, r.tag, r.words, r.err_burst, r.err_resp, nb);
        for (int b = 0; b < nb; b++) begin
            resp_q.push_back((b == int'(r.err_burst)) ? r.err_resp : resp_okay);
        end
        req.addr = r.addr;
        req.len = r.len;
        req.tag = r.tag;
        req_valid = 1'b1;
        if (!r.enable) begin
            enable = 1'b0;
            repeat (6) @(posedge clk);
            #1;
            enable = 1'b1;
        end
        await_ready(1'b0);
        req_valid = 1'b0;
        for (int k = 0; k < int'(r.words) && !timed_out; k++) begin
            s_data = chk_i.stream_word(r.tag, k);
            s_valid = 1'b1;
            s_last = k == int'(r.words) - 1;
            await_ready(1'b1);
        end
        s_valid = 1'b0;
        s_last = 1'b0;
    endtask

    initial begin
        int n;
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        s_data = '0;
        s_valid = 1'b0;
        s_last = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = resp_okay;
        enable = 1'b1;
        for (int a = 0; a < 16384; a++) mem[a] = chk_i.fill_byte(a);
        // addr, len, tag, words, error burst, response, enable
        rows[0] = '{32'h0000, 16'd64, 8'd1, 16'd16, 8'hff, resp_okay, 1'b1};
        rows[1] = '{32'h0100, 16'd32, 8'd2, 16'd8, 8'hff, resp_okay, 1'b0};
        rows[2] = '{32'h0200, 16'd200, 8'd3, 16'd50, 8'hff, resp_okay, 1'b1};
        rows[3] = '{32'h0fc8, 16'd120, 8'd4, 16'd30, 8'hff, resp_okay, 1'b1};
        rows[4] = '{32'h1400, 16'd37, 8'd5, 16'd10, 8'hff, resp_okay, 1'b1};
        rows[5] = '{32'h1800, 16'd80, 8'd6, 16'd7, 8'hff, resp_okay, 1'b1};
        rows[6] = '{32'h1900, 16'd24, 8'd7, 16'd12, 8'hff, resp_okay, 1'b1};
        rows[7] = '{32'h1a00, 16'd16, 8'd8, 16'd4, 8'hff, resp_okay, 1'b1};
        rows[8] = '{32'h2000, 16'd160, 8'd9, 16'd40, 8'd1, resp_slverr, 1'b1};
        rows[9] = '{32'h2400, 16'd100, 8'd10, 16'd25, 8'd0, resp_decerr, 1'b1};
        rows[10] = '{32'h2800, 16'd48, 8'd11, 16'd12, 8'hff, resp_okay, 1'b1};
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < 11 && !timed_out; i++) run_row(rows[i]);
        n = 0;
        while (!timed_out && chk_i.pending() != 0 && n < 5000) begin
            @(posedge clk);
            n++;
        end
        repeat (4) @(posedge clk);
        if (!timed_out) chk_i.close_out();
        $display("checks %0d errors %0d", chk_i.checks, chk_i.errors);
        if (chk_i.errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
